// File: source/mem_harness_pkg.sv
package mem_harness_pkg;

  localparam int data_width_lp         = 32;
  localparam int tag_program_cycles_lp = 8;
  localparam int reset_depth_lp        = 3;

  // channel address field widths
  localparam int bg_width_lp          = 1;
  localparam int ba_width_lp          = 2;
  localparam int ro_width_lp          = 4;
  localparam int co_width_lp          = 3;
  localparam int byte_offset_width_lp = 2;

  // word index drops the byte offset
  localparam int mem_addr_width_lp =
    ro_width_lp + bg_width_lp + ba_width_lp + co_width_lp;
  localparam int mem_words_lp      = 1 << mem_addr_width_lp;

  // counter must reach tag_program_cycles_lp itself
  localparam int tag_cnt_width_lp = $clog2(tag_program_cycles_lp + 1);

  typedef logic [bg_width_lp-1:0]          dram_bg_t;
  typedef logic [ba_width_lp-1:0]          dram_ba_t;
  typedef logic [ro_width_lp-1:0]          dram_ro_t;
  typedef logic [co_width_lp-1:0]          dram_co_t;
  typedef logic [byte_offset_width_lp-1:0] dram_byte_offset_t;

  typedef logic [data_width_lp-1:0]     data_t;
  typedef logic [mem_addr_width_lp-1:0] mem_word_addr_t;
  typedef logic [tag_cnt_width_lp-1:0]  tag_cnt_t;

  // cache side order
  typedef struct packed {
    dram_bg_t          bg;
    dram_ba_t          ba;
    dram_ro_t          ro;
    dram_co_t          co;
    dram_byte_offset_t byte_offset;
  } cache_ch_addr_s;

  // dram side order, row first
  typedef struct packed {
    dram_ro_t          ro;
    dram_bg_t          bg;
    dram_ba_t          ba;
    dram_co_t          co;
    dram_byte_offset_t byte_offset;
  } dram_ch_addr_s;

  typedef struct packed {
    logic           write_not_read;
    cache_ch_addr_s addr;
    data_t          data;
  } dma_req_s;

  typedef struct packed {
    logic          write_not_read;
    dram_ch_addr_s addr;
    data_t         data;
  } dram_req_s;

  typedef struct packed {
    dram_ch_addr_s addr;
    data_t         data;
  } dram_rsp_s;

  typedef struct packed {
    cache_ch_addr_s addr;
    data_t          data;
  } dma_rsp_s;

endpackage

// File: source/mem_reset_ctrl.sv
`timescale 1ns/1ps

module mem_reset_ctrl
  import mem_harness_pkg::*;
  (
    input clk_i
    , input rst_i

    , output logic tag_done_o
    , output logic core_reset_o
    , output logic mem_ready_o
  );

  typedef enum logic {
    tag_program
    , tag_done
  } tag_state_e;

  tag_state_e state_r;
  tag_state_e state_n;
  tag_cnt_t   cnt_r;
  logic       cnt_hit;

  logic [reset_depth_lp-1:0] reset_chain_r;

  // programming ends once the counter has seen every cycle
  assign cnt_hit = (cnt_r == tag_cnt_t'(tag_program_cycles_lp));

  always_comb begin
    state_n = state_r;
    case (state_r)
      tag_program: begin
        if (cnt_hit) begin
          state_n = tag_done;
        end
      end
      tag_done: begin
        state_n = tag_done;
      end
      default: begin
        state_n = tag_program;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= tag_program;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (state_r == tag_program && !cnt_hit) begin
        cnt_r <= cnt_r + 1'b1;
      end
    end
  end

  assign tag_done_o = (state_r == tag_done);

  // hold the memory side in reset until done has crossed the chain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      reset_chain_r <= '1;
    end else begin
      reset_chain_r <= {reset_chain_r[reset_depth_lp-2:0], ~tag_done_o};
    end
  end

  assign core_reset_o = reset_chain_r[reset_depth_lp-1];
  assign mem_ready_o  = ~core_reset_o;

endmodule

// File: source/dma_addr_map.sv
`timescale 1ns/1ps

module dma_addr_map
  import mem_harness_pkg::*;
  (
    input clk_i
    , input core_reset_i

    , input           dma_v_i
    , input dma_req_s dma_req_i

    , output logic      dram_v_o
    , output dram_req_s dram_req_o
  );

  dram_ch_addr_s dram_addr;
  dram_req_s     dram_req_n;
  logic          dram_v_r;
  dram_req_s     dram_req_r;

  // same fields, dram order
  always_comb begin
    dram_addr.ro          = dma_req_i.addr.ro;
    dram_addr.bg          = dma_req_i.addr.bg;
    dram_addr.ba          = dma_req_i.addr.ba;
    dram_addr.co          = dma_req_i.addr.co;
    dram_addr.byte_offset = dma_req_i.addr.byte_offset;
  end

  always_comb begin
    dram_req_n.write_not_read = dma_req_i.write_not_read;
    dram_req_n.addr           = dram_addr;
    dram_req_n.data           = dma_req_i.data;
  end

  // strobes during core reset are dropped here
  always_ff @(posedge clk_i) begin
    if (core_reset_i) begin
      dram_v_r <= 1'b0;
    end else begin
      dram_v_r <= dma_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_v_i) begin
      dram_req_r <= dram_req_n;
    end
  end

  assign dram_v_o   = dram_v_r;
  assign dram_req_o = dram_req_r;

endmodule

// File: source/test_dram.sv
`timescale 1ns/1ps

module test_dram
  import mem_harness_pkg::*;
  (
    input clk_i
    , input core_reset_i

    , input            dram_v_i
    , input dram_req_s dram_req_i

    , output logic      read_v_o
    , output dram_rsp_s read_o
  );

  data_t mem_r [mem_words_lp];

  mem_word_addr_t word_addr;
  logic           req_fire;
  logic           wr_fire;
  logic           rd_fire;
  logic           read_v_r;
  dram_rsp_s      read_r;

  // byte offset never reaches the word index
  assign word_addr = {dram_req_i.addr.ro, dram_req_i.addr.bg,
                      dram_req_i.addr.ba, dram_req_i.addr.co};

  assign req_fire = dram_v_i & ~core_reset_i;
  assign wr_fire  = req_fire & dram_req_i.write_not_read;
  assign rd_fire  = req_fire & ~dram_req_i.write_not_read;

  // memory starts cleared
  initial begin
    for (int i = 0; i < mem_words_lp; i++) begin
      mem_r[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_r[word_addr] <= dram_req_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (core_reset_i) begin
      read_v_r <= 1'b0;
    end else begin
      read_v_r <= rd_fire;
    end
  end

  // read data travels with its channel address
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      read_r.addr <= dram_req_i.addr;
      read_r.data <= mem_r[word_addr];
    end
  end

  assign read_v_o = read_v_r;
  assign read_o   = read_r;

endmodule

// File: source/read_done_unmap.sv
`timescale 1ns/1ps

module read_done_unmap
  import mem_harness_pkg::*;
  (
    input clk_i
    , input core_reset_i

    , input            read_v_i
    , input dram_rsp_s read_i

    , output logic     rsp_v_o
    , output dma_rsp_s rsp_o
  );

  cache_ch_addr_s cache_addr;
  logic           rsp_v_r;
  dma_rsp_s       rsp_r;

  // back to cache order, field by field
  always_comb begin
    cache_addr.bg          = read_i.addr.bg;
    cache_addr.ba          = read_i.addr.ba;
    cache_addr.ro          = read_i.addr.ro;
    cache_addr.co          = read_i.addr.co;
    cache_addr.byte_offset = read_i.addr.byte_offset;
  end

  always_ff @(posedge clk_i) begin
    if (core_reset_i) begin
      rsp_v_r <= 1'b0;
    end else begin
      rsp_v_r <= read_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_v_i) begin
      rsp_r.addr <= cache_addr;
      rsp_r.data <= read_i.data;
    end
  end

  assign rsp_v_o = rsp_v_r;
  assign rsp_o   = rsp_r;

endmodule

// File: source/manycore_mem_harness.sv
`timescale 1ns/1ps

module manycore_mem_harness
  import mem_harness_pkg::*;
  (
    input clk_i
    , input rst_i

    , input           dma_v_i
    , input dma_req_s dma_req_i

    , output logic     tag_done_o
    , output logic     mem_ready_o
    , output logic     rsp_v_o
    , output dma_rsp_s rsp_o
  );

  logic core_reset;

  // request path into the dram
  logic      dram_v;
  dram_req_s dram_req;

  // read completions out of the dram
  logic      read_v;
  dram_rsp_s read_rsp;

  mem_reset_ctrl reset_ctrl (
    .clk_i(clk_i)
    ,.rst_i(rst_i)

    ,.tag_done_o(tag_done_o)
    ,.core_reset_o(core_reset)
    ,.mem_ready_o(mem_ready_o)
  );

  dma_addr_map addr_map (
    .clk_i(clk_i)
    ,.core_reset_i(core_reset)

    ,.dma_v_i(dma_v_i)
    ,.dma_req_i(dma_req_i)

    ,.dram_v_o(dram_v)
    ,.dram_req_o(dram_req)
  );

  test_dram dram (
    .clk_i(clk_i)
    ,.core_reset_i(core_reset)

    ,.dram_v_i(dram_v)
    ,.dram_req_i(dram_req)

    ,.read_v_o(read_v)
    ,.read_o(read_rsp)
  );

  read_done_unmap unmap (
    .clk_i(clk_i)
    ,.core_reset_i(core_reset)

    ,.read_v_i(read_v)
    ,.read_i(read_rsp)

    ,.rsp_v_o(rsp_v_o)
    ,.rsp_o(rsp_o)
  );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
  );

  // 4 ns period
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #2 clk_o = ~clk_o;
  end

endmodule

// File: dv/manycore_mem_harness_properties.sv
`timescale 1ns/1ps

module manycore_mem_harness_properties
  import mem_harness_pkg::*;
  (
    input clk_i
    , input rst_i

    , input           dma_v_i
    , input dma_req_s dma_req_i

    , input           tag_done_o
    , input           mem_ready_o
    , input           rsp_v_o
    , input dma_rsp_s rsp_o
  );

  logic           read_accept;
  cache_ch_addr_s req_addr;

  assign read_accept = dma_v_i & ~dma_req_i.write_not_read & mem_ready_o;
  assign req_addr    = dma_req_i.addr;

  // outputs quiet once reset has settled
  reset_quiet: assert property (@(posedge clk_i)
    $past(rst_i) && $past(rst_i, 2) |-> !tag_done_o && !mem_ready_o && !rsp_v_o)
    else $error("tag_done, mem_ready or rsp_v high during reset");

  tag_done_timing: assert property (@(posedge clk_i)
    $fell(rst_i) |-> ##(tag_program_cycles_lp + 1) $rose(tag_done_o))
    else $error("tag_done did not rise at the programmed cycle");

  ready_timing: assert property (@(posedge clk_i)
    $rose(tag_done_o) |-> ##reset_depth_lp $rose(mem_ready_o))
    else $error("mem_ready did not follow tag_done through the reset chain");

  done_hold: assert property (@(posedge clk_i)
    !rst_i && tag_done_o |=> tag_done_o)
    else $error("tag_done dropped without reset");

  ready_hold: assert property (@(posedge clk_i)
    !rst_i && mem_ready_o |=> mem_ready_o)
    else $error("mem_ready dropped without reset");

  // three stages from accept to response
  read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    read_accept |-> ##3 (rsp_v_o && rsp_o.addr == $past(req_addr, 3)))
    else $error("read response late or carrying the wrong address");

  no_stray_rsp: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_v_o |-> $past(read_accept, 3))
    else $error("response without an accepted read three cycles earlier");

endmodule

bind manycore_mem_harness manycore_mem_harness_properties props (
  .clk_i(clk_i)
  ,.rst_i(rst_i)
  ,.dma_v_i(dma_v_i)
  ,.dma_req_i(dma_req_i)
  ,.tag_done_o(tag_done_o)
  ,.mem_ready_o(mem_ready_o)
  ,.rsp_v_o(rsp_v_o)
  ,.rsp_o(rsp_o)
);

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top
  import mem_harness_pkg::*;
  ();

  localparam int timeout_cycles_lp = 600;
  localparam int read_latency_lp   = 3;
  localparam int fill_words_lp     = 64;
  localparam int burst_len_lp      = 80;

  typedef struct packed {
    cache_ch_addr_s addr;
    data_t          data;
    logic [31:0]    stamp;
  } expect_s;

  logic     clk;
  logic     rst;
  logic     dma_v;
  dma_req_s dma_req;
  logic     tag_done;
  logic     mem_ready;
  logic     rsp_v;
  dma_rsp_s rsp;

  // words never written read back as zero
  data_t          ref_mem [mem_word_addr_t];
  expect_s        pending [$];
  cache_ch_addr_s fill_addrs [fill_words_lp];

  logic [31:0] cycle_cnt  = '0;
  int unsigned reads_sent = 0;
  int unsigned rsp_cnt    = 0;
  string       test_name  = "reset";

  tb_clock clock_gen (
    .clk_o(clk)
  );

  manycore_mem_harness dut (
    .clk_i(clk)
    ,.rst_i(rst)
    ,.dma_v_i(dma_v)
    ,.dma_req_i(dma_req)
    ,.tag_done_o(tag_done)
    ,.mem_ready_o(mem_ready)
    ,.rsp_v_o(rsp_v)
    ,.rsp_o(rsp)
  );

  function automatic mem_word_addr_t word_index(input cache_ch_addr_s a);
    return {a.ro, a.bg, a.ba, a.co};
  endfunction

  function automatic data_t expected_word(input mem_word_addr_t idx);
    if (ref_mem.exists(idx)) begin
      return ref_mem[idx];
    end
    return '0;
  endfunction

  function automatic cache_ch_addr_s random_addr();
    logic [31:0] r;
    r = $urandom;
    return r[11:0];
  endfunction

  task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
    stop_with_failure();
  endtask

  task automatic send_request(input logic wnr, input cache_ch_addr_s addr, input data_t data);
    @(posedge clk);
    dma_v                  <= 1'b1;
    dma_req.write_not_read <= wnr;
    dma_req.addr           <= addr;
    dma_req.data           <= data;
  endtask

  task automatic go_idle();
    @(posedge clk);
    dma_v   <= 1'b0;
    dma_req <= '0;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles_lp) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles_lp);
      stop_with_failure();
    end
  end

  // responses handled before the request seen this cycle
  always @(negedge clk) begin : monitor
    expect_s entry;
    expect_s exp_rsp;
    if (rsp_v) begin
      assert (pending.size() != 0) else begin
        $display("response in %s with no read outstanding", test_name);
        stop_with_failure();
      end
      exp_rsp = pending.pop_front();
      rsp_cnt++;
      assert (rsp.data == exp_rsp.data)
        else report_mismatch("data", exp_rsp.data, rsp.data);
      assert (rsp.addr == exp_rsp.addr)
        else report_mismatch("addr", {20'd0, exp_rsp.addr}, {20'd0, rsp.addr});
      assert (cycle_cnt - exp_rsp.stamp == read_latency_lp)
        else report_mismatch("latency", read_latency_lp, cycle_cnt - exp_rsp.stamp);
    end
    // requests while not ready are dropped
    if (dma_v && mem_ready) begin
      if (dma_req.write_not_read) begin
        ref_mem[word_index(dma_req.addr)] = dma_req.data;
      end else begin
        entry.addr  = dma_req.addr;
        entry.data  = expected_word(word_index(dma_req.addr));
        entry.stamp = cycle_cnt;
        pending.push_back(entry);
      end
    end
  end

  initial begin
    cache_ch_addr_s drop_addrs [4];
    cache_ch_addr_s addr;
    logic [31:0]    r;
    int             idx;

    void'($urandom(32'h6d32c0fa));
    rst     = 1'b1;
    dma_v   = 1'b0;
    dma_req = '0;

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // writes and reads during tag programming
    test_name = "drop_before_ready";
    for (int i = 0; i < 4; i++) begin
      drop_addrs[i] = random_addr();
      send_request(1'b1, drop_addrs[i], $urandom);
      send_request(1'b0, drop_addrs[i], '0);
    end
    go_idle();

    while (!mem_ready) @(negedge clk);

    for (int i = 0; i < 4; i++) begin
      send_request(1'b0, drop_addrs[i], '0);
      reads_sent++;
    end
    go_idle();

    test_name = "write_then_read";
    for (int i = 0; i < fill_words_lp; i++) begin
      fill_addrs[i] = random_addr();
      send_request(1'b1, fill_addrs[i], $urandom);
    end
    for (int i = 0; i < fill_words_lp; i++) begin
      send_request(1'b0, fill_addrs[i], '0);
      reads_sent++;
    end
    go_idle();

    // one request per cycle in mixed directions
    test_name = "burst";
    for (int i = 0; i < burst_len_lp; i++) begin
      idx              = $urandom_range(fill_words_lp - 1, 0);
      r                = $urandom;
      addr             = fill_addrs[idx];
      addr.byte_offset = r[1:0];
      send_request(r[2], addr, $urandom);
      if (!r[2]) begin
        reads_sent++;
      end
    end
    go_idle();

    while (pending.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);

    if (pending.size() == 0 && rsp_cnt == reads_sent) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("%0d reads sent but %0d responses seen", reads_sent, rsp_cnt);
      stop_with_failure();
    end
  end

endmodule

// File: filelist.f
source/mem_harness_pkg.sv
source/mem_reset_ctrl.sv
source/dma_addr_map.sv
source/test_dram.sv
source/read_done_unmap.sv
source/manycore_mem_harness.sv
dv/tb_clock.sv
dv/manycore_mem_harness_properties.sv
dv/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
